// ==== logic/legIsaPkg.sv ====
package legIsaPkg;

	// R-format, register to register arithmetic
	typedef struct packed {
		logic [10:0] opcode;
		logic [4:0]  rm;
		logic [5:0]  shamt;
		logic [4:0]  rn;
		logic [4:0]  rd;
	} rFmtT;

	// I-format with unsigned 12-bit immediate
	typedef struct packed {
		logic [9:0]  opcode;
		logic [11:0] imm12;
		logic [4:0]  rn;
		logic [4:0]  rd;
	} iFmtT;

	// D-format loads and stores
	typedef struct packed {
		logic [10:0] opcode;
		logic [8:0]  addr9;
		logic [1:0]  op2;
		logic [4:0]  rn;
		logic [4:0]  rt;
	} dFmtT;

	// CB-format, compare and branch
	typedef struct packed {
		logic [7:0]  opcode;
		logic [18:0] addr19;
		logic [4:0]  rt;
	} cbFmtT;

	// B-format, word offset only
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] addr26;
	} bFmtT;

	// One instruction word seen in each of its five layouts
	typedef union packed {
		rFmtT  rFmt;
		iFmtT  iFmt;
		dFmtT  dFmt;
		cbFmtT cbFmt;
		bFmtT  bFmt;
	} instrWord;

	// Opcode patterns, each at its own format width
	localparam logic [9:0]  opAddi = 10'b1001000100;
	localparam logic [10:0] opAdds = 11'b10101011000;
	localparam logic [10:0] opSubs = 11'b11101011000;
	localparam logic [10:0] opLdur = 11'b11111000010;
	localparam logic [10:0] opStur = 11'b11111000000;
	localparam logic [7:0]  opCbz  = 8'b10110100;
	localparam logic [5:0]  opBl   = 6'b100101;

endpackage

// ==== logic/legCtrlPkg.sv ====
package legCtrlPkg;

	// ALU control codes
	localparam logic [2:0] aluPassPc   = 3'b000;
	localparam logic [2:0] aluAdd      = 3'b010;
	localparam logic [2:0] aluSub      = 3'b011;
	// CBZ passes the tested register through
	localparam logic [2:0] aluZeroTest = 3'b100;

	// Bit positions inside the NZVC word
	localparam int flagN = 3;
	localparam int flagZ = 2;
	localparam int flagV = 1;
	localparam int flagC = 0;

	// Datapath widths
	localparam int dataWidth    = 64;
	localparam int regAddrWidth = 5;

	// Data memory geometry, in doublewords
	localparam int memDepth      = 32;
	localparam int memIndexWidth = 5;

	// BL link register
	localparam logic [4:0] linkReg = 5'd30;

endpackage

// ==== logic/aluControlUnit.sv ====
`timescale 1ns/100ps

module aluControlUnit import legIsaPkg::*, legCtrlPkg::*; (
	input  logic [10:0] opcode,
	input  logic        aluOn,
	output logic [2:0]  aluCtrl,
	output logic        supported
);

	// Opcode field cut at each format width
	logic [10:0] rOp;
	logic [10:0] dOp;
	logic [9:0]  iOp;
	logic [7:0]  cbOp;
	logic [5:0]  bOp;

	assign rOp  = opcode;
	assign dOp  = opcode;
	assign iOp  = opcode[10:1];
	assign cbOp = opcode[10:3];
	assign bOp  = opcode[10:5];

	always_comb begin
		// Safe default, never X downstream
		aluCtrl   = aluAdd;
		supported = 1'b0;
		if (aluOn) begin
			// ADDI and ADDS add
			if (iOp == opAddi || rOp == opAdds) begin
				aluCtrl   = aluAdd;
				supported = 1'b1;
			end
			// Address generation for STUR and LDUR
			else if (dOp == opStur || dOp == opLdur) begin
				aluCtrl   = aluAdd;
				supported = 1'b1;
			end
			// SUBS
			else if (rOp == opSubs) begin
				aluCtrl   = aluSub;
				supported = 1'b1;
			end
			// BL, link value comes from the pc
			else if (bOp == opBl) begin
				aluCtrl   = aluPassPc;
				supported = 1'b1;
			end
			// CBZ zero test on rt
			else if (cbOp == opCbz) begin
				aluCtrl   = aluZeroTest;
				supported = 1'b1;
			end
			// Anything else stays unsupported
		end
	end

endmodule

// ==== logic/instrFrontEnd.sv ====
`timescale 1ns/100ps

module instrFrontEnd import legIsaPkg::*, legCtrlPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [31:0]             instr,
	input  logic                    instrValid,
	input  logic [dataWidth-1:0]    nextPc,
	output logic [dataWidth-1:0]    pc,
	output logic [regAddrWidth-1:0] rdAddrA,
	output logic [regAddrWidth-1:0] rdAddrB,
	output logic [2:0]              aluCtrl,
	output logic [dataWidth-1:0]    imm,
	output logic                    useImm,
	output logic                    setFlags,
	output logic                    isCbz,
	output logic                    isBl,
	output logic [dataWidth-1:0]    branchOffset,
	output logic                    memRead,
	output logic                    memWrite,
	output logic                    regWe,
	output logic [regAddrWidth-1:0] regWeAddr,
	output logic                    illegal
);

	instrWord word;
	logic     aluOn;
	logic     supported;
	logic     isAddi;
	logic     isAdds;
	logic     isSubs;
	logic     isLdur;
	logic     isStur;

	assign word = instr;

	// Class decode, one compare per format
	assign isAddi = word.iFmt.opcode == opAddi;
	assign isAdds = word.rFmt.opcode == opAdds;
	assign isSubs = word.rFmt.opcode == opSubs;
	assign isLdur = word.dFmt.opcode == opLdur;
	assign isStur = word.dFmt.opcode == opStur;
	assign isCbz  = word.cbFmt.opcode == opCbz;
	assign isBl   = word.bFmt.opcode == opBl;

	// Every class uses the ALU while strobed
	assign aluOn = instrValid;

	aluControlUnit aluCtl (
		.opcode    (word.rFmt.opcode),
		.aluOn     (aluOn),
		.aluCtrl   (aluCtrl),
		.supported (supported)
	);

	assign illegal = !supported;

	// rn sits in the same bits for R, I and D
	assign rdAddrA = word.rFmt.rn;
	// Second port is rm for R, else rt (same bits in D and CB)
	assign rdAddrB = (isAdds || isSubs) ? word.rFmt.rm : word.dFmt.rt;

	// imm12 zero extended, addr9 sign extended
	assign imm = isAddi ? {{(dataWidth-12){1'b0}}, word.iFmt.imm12}
	                    : {{(dataWidth-9){word.dFmt.addr9[8]}}, word.dFmt.addr9};
	assign useImm = isAddi || isLdur || isStur;
	assign setFlags = isAdds || isSubs;

	// Word offsets turned into byte offsets
	assign branchOffset = isBl
		? {{(dataWidth-28){word.bFmt.addr26[25]}}, word.bFmt.addr26, 2'b00}
		: {{(dataWidth-21){word.cbFmt.addr19[18]}}, word.cbFmt.addr19, 2'b00};

	assign memRead  = isLdur;
	assign memWrite = isStur;
	assign regWe    = isAddi || isAdds || isSubs || isLdur || isBl;
	// BL links into X30
	assign regWeAddr = isBl ? linkReg : word.rFmt.rd;

	// Program counter, advances only on a strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (instrValid) begin
			pc <= nextPc;
		end
	end

endmodule

// ==== logic/registerFile.sv ====
`timescale 1ns/100ps

module registerFile import legCtrlPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [regAddrWidth-1:0] rdAddrA,
	input  logic [regAddrWidth-1:0] rdAddrB,
	output logic [dataWidth-1:0]    rdDataA,
	output logic [dataWidth-1:0]    rdDataB,
	input  logic                    wrEn,
	input  logic [regAddrWidth-1:0] wrAddr,
	input  logic [dataWidth-1:0]    wrData
);

	// X31 has no storage
	localparam logic [regAddrWidth-1:0] zeroReg = '1;

	logic [dataWidth-1:0] regs [0:30];

	// Combinational reads, X31 forced to zero
	assign rdDataA = (rdAddrA == zeroReg) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == zeroReg) ? '0 : regs[rdAddrB];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 31; i++) begin
				regs[i] <= '0;
			end
		end
		// Writes to X31 are dropped
		else if (wrEn && wrAddr != zeroReg) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

// ==== logic/executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit import legCtrlPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 instrValid,
	input  logic [2:0]           aluCtrl,
	input  logic [dataWidth-1:0] opA,
	input  logic [dataWidth-1:0] opB,
	input  logic [dataWidth-1:0] imm,
	input  logic                 useImm,
	input  logic                 setFlags,
	input  logic                 isCbz,
	input  logic                 isBl,
	input  logic [dataWidth-1:0] pc,
	input  logic [dataWidth-1:0] branchOffset,
	input  logic                 illegal,
	output logic [dataWidth-1:0] aluResult,
	output logic [3:0]           flags,
	output logic [dataWidth-1:0] nextPc
);

	logic [dataWidth-1:0] operand;
	logic [dataWidth-1:0] addend;
	logic                 isSub;
	logic [dataWidth:0]   sumWide;
	logic [dataWidth-1:0] sum;
	logic                 overflow;
	logic [dataWidth-1:0] pcPlus4;
	logic                 cbzTaken;
	logic [3:0]           flagReg;
	logic [3:0]           flagsNew;
	logic                 flagLoad;

	// Immediate or second register
	assign operand = useImm ? imm : opB;

	// Subtract as opA + ~operand + 1
	assign isSub   = aluCtrl == aluSub;
	assign addend  = isSub ? ~operand : operand;
	assign sumWide = {1'b0, opA} + {1'b0, addend} + {{dataWidth{1'b0}}, isSub};
	assign sum     = sumWide[dataWidth-1:0];

	// Same-sign inputs giving an opposite-sign result
	assign overflow = (opA[dataWidth-1] == addend[dataWidth-1])
	               && (sum[dataWidth-1] != opA[dataWidth-1]);

	assign pcPlus4 = pc + 64'd4;

	always_comb begin
		case (aluCtrl)
			aluPassPc:   aluResult = pcPlus4;
			aluZeroTest: aluResult = opB;
			default:     aluResult = sum;
		endcase
	end

	// Branch resolution
	assign cbzTaken = isCbz && (aluResult == '0);
	assign nextPc   = (!illegal && (isBl || cbzTaken)) ? pc + branchOffset : pcPlus4;

	always_comb begin
		flagsNew        = '0;
		flagsNew[flagN] = sum[dataWidth-1];
		flagsNew[flagZ] = sum == '0;
		flagsNew[flagV] = overflow;
		flagsNew[flagC] = sumWide[dataWidth];
	end

	// Only strobed, legal ADDS and SUBS touch the flags
	assign flagLoad = instrValid && !illegal && setFlags;

	always_ff @(posedge clk) begin
		if (rst) begin
			flagReg <= '0;
		end else if (flagLoad) begin
			flagReg <= flagsNew;
		end
	end

	// Flags as they stand after this instruction
	assign flags = flagLoad ? flagsNew : flagReg;

endmodule

// ==== logic/dataMemory.sv ====
`timescale 1ns/100ps

module dataMemory import legCtrlPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instrValid,
	input  logic [dataWidth-1:0]    pc,
	input  logic                    memRead,
	input  logic                    memWrite,
	input  logic [dataWidth-1:0]    memAddr,
	input  logic [dataWidth-1:0]    storeData,
	input  logic                    regWe,
	input  logic [regAddrWidth-1:0] regWeAddr,
	input  logic [dataWidth-1:0]    aluResult,
	input  logic                    illegal,
	input  logic [3:0]              flags,
	output logic                    regWrite,
	output logic [regAddrWidth-1:0] regWriteAddr,
	output logic [dataWidth-1:0]    regWriteData,
	output logic                    retireValid,
	output logic [dataWidth-1:0]    retirePc,
	output logic                    retireIllegal,
	output logic                    retireRegWe,
	output logic [regAddrWidth-1:0] retireRegAddr,
	output logic [dataWidth-1:0]    retireRegData,
	output logic                    retireMemWe,
	output logic [dataWidth-1:0]    retireMemAddr,
	output logic [dataWidth-1:0]    retireMemData,
	output logic [3:0]              retireFlags
);

	logic [dataWidth-1:0]     mem [0:memDepth-1];
	logic [memIndexWidth-1:0] memIndex;
	logic [dataWidth-1:0]     loadData;
	logic                     commit;

	// Doubleword index, low three bits ignored
	assign memIndex = memAddr[memIndexWidth+2:3];
	assign loadData = mem[memIndex];

	// A legal strobed instruction may write state
	assign commit = instrValid && !illegal;

	// Write-back to the register file
	assign regWrite     = commit && regWe;
	assign regWriteAddr = regWeAddr;
	assign regWriteData = memRead ? loadData : aluResult;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < memDepth; i++) begin
				mem[i] <= '0;
			end
		end else if (commit && memWrite) begin
			mem[memIndex] <= storeData;
		end
	end

	// Retire control bits, pulse for one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			retireValid   <= 1'b0;
			retireIllegal <= 1'b0;
			retireRegWe   <= 1'b0;
			retireMemWe   <= 1'b0;
		end else begin
			retireValid   <= instrValid;
			retireIllegal <= instrValid && illegal;
			// X31 destination is not an effective write
			retireRegWe   <= regWrite && (regWeAddr != '1);
			retireMemWe   <= commit && memWrite;
		end
	end

	// Retire payload
	always_ff @(posedge clk) begin
		if (instrValid) begin
			retirePc      <= pc;
			retireRegAddr <= regWeAddr;
			retireRegData <= regWriteData;
			retireMemAddr <= memAddr;
			retireMemData <= storeData;
			retireFlags   <= flags;
		end
	end

endmodule

// ==== logic/legCore.sv ====
`timescale 1ns/100ps

module legCore import legCtrlPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [31:0]             instr,
	input  logic                    instrValid,
	output logic                    retireValid,
	output logic [dataWidth-1:0]    retirePc,
	output logic                    retireIllegal,
	output logic                    retireRegWe,
	output logic [regAddrWidth-1:0] retireRegAddr,
	output logic [dataWidth-1:0]    retireRegData,
	output logic                    retireMemWe,
	output logic [dataWidth-1:0]    retireMemAddr,
	output logic [dataWidth-1:0]    retireMemData,
	output logic [3:0]              retireFlags
);

	// Front end outputs
	logic [dataWidth-1:0]    pc;
	logic [regAddrWidth-1:0] rdAddrA;
	logic [regAddrWidth-1:0] rdAddrB;
	logic [2:0]              aluCtrl;
	logic [dataWidth-1:0]    imm;
	logic                    useImm;
	logic                    setFlags;
	logic                    isCbz;
	logic                    isBl;
	logic [dataWidth-1:0]    branchOffset;
	logic                    memRead;
	logic                    memWrite;
	logic                    regWe;
	logic [regAddrWidth-1:0] regWeAddr;
	logic                    illegal;
	// Register file ports
	logic [dataWidth-1:0]    rdDataA;
	logic [dataWidth-1:0]    rdDataB;
	logic                    regWrite;
	logic [regAddrWidth-1:0] regWriteAddr;
	logic [dataWidth-1:0]    regWriteData;
	// Execute results
	logic [dataWidth-1:0]    aluResult;
	logic [3:0]              flags;
	logic [dataWidth-1:0]    nextPc;

	instrFrontEnd frontEnd (
		.clk          (clk),
		.rst          (rst),
		.instr        (instr),
		.instrValid   (instrValid),
		.nextPc       (nextPc),
		.pc           (pc),
		.rdAddrA      (rdAddrA),
		.rdAddrB      (rdAddrB),
		.aluCtrl      (aluCtrl),
		.imm          (imm),
		.useImm       (useImm),
		.setFlags     (setFlags),
		.isCbz        (isCbz),
		.isBl         (isBl),
		.branchOffset (branchOffset),
		.memRead      (memRead),
		.memWrite     (memWrite),
		.regWe        (regWe),
		.regWeAddr    (regWeAddr),
		.illegal      (illegal)
	);

	registerFile regFile (
		.clk     (clk),
		.rst     (rst),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (regWrite),
		.wrAddr  (regWriteAddr),
		.wrData  (regWriteData)
	);

	executeUnit execute (
		.clk          (clk),
		.rst          (rst),
		.instrValid   (instrValid),
		.aluCtrl      (aluCtrl),
		.opA          (rdDataA),
		.opB          (rdDataB),
		.imm          (imm),
		.useImm       (useImm),
		.setFlags     (setFlags),
		.isCbz        (isCbz),
		.isBl         (isBl),
		.pc           (pc),
		.branchOffset (branchOffset),
		.illegal      (illegal),
		.aluResult    (aluResult),
		.flags        (flags),
		.nextPc       (nextPc)
	);

	// Store data is the rt register on port B
	dataMemory dataMem (
		.clk           (clk),
		.rst           (rst),
		.instrValid    (instrValid),
		.pc            (pc),
		.memRead       (memRead),
		.memWrite      (memWrite),
		.memAddr       (aluResult),
		.storeData     (rdDataB),
		.regWe         (regWe),
		.regWeAddr     (regWeAddr),
		.aluResult     (aluResult),
		.illegal       (illegal),
		.flags         (flags),
		.regWrite      (regWrite),
		.regWriteAddr  (regWriteAddr),
		.regWriteData  (regWriteData),
		.retireValid   (retireValid),
		.retirePc      (retirePc),
		.retireIllegal (retireIllegal),
		.retireRegWe   (retireRegWe),
		.retireRegAddr (retireRegAddr),
		.retireRegData (retireRegData),
		.retireMemWe   (retireMemWe),
		.retireMemAddr (retireMemAddr),
		.retireMemData (retireMemData),
		.retireFlags   (retireFlags)
	);

endmodule

// ==== tests/legModel.svh ====
`ifndef legModelSvh
`define legModelSvh

// Architectural state of the model
logic [63:0] archRegs [0:31];
logic [63:0] archMem [0:memDepth-1];
logic [63:0] archPc;
logic [3:0]  archFlags;

// Expected retire record for the cycle just issued
logic        expValid;
logic        expIllegal;
logic        expRegWe;
logic [4:0]  expRegAddr;
logic [63:0] expRegData;
logic        expMemWe;
logic [63:0] expMemAddr;
logic [63:0] expMemData;
logic [63:0] expPc;
logic [3:0]  expFlags;

// No strobe this cycle
task automatic expectIdle();
	expValid   = 1'b0;
	expIllegal = 1'b0;
	expRegWe   = 1'b0;
	expMemWe   = 1'b0;
endtask

task automatic clearArchState();
	for (int i = 0; i < 32; i++) begin
		archRegs[i] = '0;
	end
	for (int i = 0; i < memDepth; i++) begin
		archMem[i] = '0;
	end
	archPc    = '0;
	archFlags = '0;
	expectIdle();
endtask

// X31 is the zero register
function automatic logic [63:0] archRead(input logic [4:0] r);
	return (r == 5'd31) ? 64'd0 : archRegs[r];
endfunction

// Expected retire record, then state update
task automatic predictRetire(input logic [31:0] w);
	instrWord    u;
	logic [63:0] a;
	logic [63:0] b;
	logic [63:0] res;
	logic [63:0] addr;
	logic [63:0] target;
	logic [64:0] wide;
	logic [4:0]  dest;
	logic        writes;
	logic        ovf;
	u      = w;
	a      = archRead(u.rFmt.rn);
	b      = archRead(u.rFmt.rm);
	res    = '0;
	dest   = u.rFmt.rd;
	writes = 1'b0;
	target = archPc + 64'd4;
	expValid   = 1'b1;
	expPc      = archPc;
	expIllegal = 1'b0;
	expRegWe   = 1'b0;
	expMemWe   = 1'b0;
	if (u.iFmt.opcode == opAddi) begin
		// Unsigned immediate
		res    = a + {52'd0, u.iFmt.imm12};
		writes = 1'b1;
	end else if (u.rFmt.opcode == opAdds || u.rFmt.opcode == opSubs) begin
		if (u.rFmt.opcode == opSubs) begin
			// a plus not b plus one, carry out is C
			wide = {1'b0, a} + {1'b0, ~b} + 65'd1;
			ovf  = (a[63] != b[63]) && (wide[63] != a[63]);
		end else begin
			wide = {1'b0, a} + {1'b0, b};
			ovf  = (a[63] == b[63]) && (wide[63] != a[63]);
		end
		res    = wide[63:0];
		writes = 1'b1;
		archFlags[flagN] = res[63];
		archFlags[flagZ] = (res == 64'd0);
		archFlags[flagV] = ovf;
		archFlags[flagC] = wide[64];
	end else if (u.dFmt.opcode == opLdur || u.dFmt.opcode == opStur) begin
		addr = a + {{55{u.dFmt.addr9[8]}}, u.dFmt.addr9};
		if (u.dFmt.opcode == opStur) begin
			expMemWe   = 1'b1;
			expMemAddr = addr;
			expMemData = archRead(u.dFmt.rt);
			archMem[addr[7:3]] = expMemData;
		end else begin
			res    = archMem[addr[7:3]];
			writes = 1'b1;
		end
	end else if (u.cbFmt.opcode == opCbz) begin
		if (archRead(u.cbFmt.rt) == 64'd0) begin
			target = archPc + {{43{u.cbFmt.addr19[18]}}, u.cbFmt.addr19, 2'b00};
		end
	end else if (u.bFmt.opcode == opBl) begin
		// Link into X30
		res    = archPc + 64'd4;
		dest   = linkReg;
		writes = 1'b1;
		target = archPc + {{36{u.bFmt.addr26[25]}}, u.bFmt.addr26, 2'b00};
	end else begin
		expIllegal = 1'b1;
	end
	if (writes && dest != 5'd31) begin
		archRegs[dest] = res;
		expRegWe       = 1'b1;
		expRegAddr     = dest;
		expRegData     = res;
	end
	expFlags = archFlags;
	archPc   = target;
endtask

`endif

// ==== tests/legCoreTb.sv ====
`timescale 1ns/100ps

module legCoreTb import legIsaPkg::*, legCtrlPkg::*; ();

	// Test lengths in instructions
	localparam int idleCount    = 8;
	localparam int arithCount   = 80;
	localparam int chainCount   = 68;
	localparam int memPairs     = 20;
	localparam int ctrlCount    = 30;
	localparam int illegalCount = 40;
	localparam int mixedCount   = 200;
	localparam int totalInstr   = idleCount + 1 + arithCount + chainCount + 2 * memPairs
	                            + ctrlCount + illegalCount + mixedCount;
	localparam int watchdogNs   = (16 + totalInstr + 10) * 40 * 2;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] instr;
	logic        instrValid;
	logic        retireValid;
	logic [63:0] retirePc;
	logic        retireIllegal;
	logic        retireRegWe;
	logic [4:0]  retireRegAddr;
	logic [63:0] retireRegData;
	logic        retireMemWe;
	logic [63:0] retireMemAddr;
	logic [63:0] retireMemData;
	logic [3:0]  retireFlags;

	integer seed;
	int     errorCount;
	int     checkCount;
	int     cycleCount;
	int     testsPassed;
	int     testsFailed;

	`include "legModel.svh"

	// 40 ns period
	always #20 clk = ~clk;

	legCore DUT (
		.clk           (clk),
		.rst           (rst),
		.instr         (instr),
		.instrValid    (instrValid),
		.retireValid   (retireValid),
		.retirePc      (retirePc),
		.retireIllegal (retireIllegal),
		.retireRegWe   (retireRegWe),
		.retireRegAddr (retireRegAddr),
		.retireRegData (retireRegData),
		.retireMemWe   (retireMemWe),
		.retireMemAddr (retireMemAddr),
		.retireMemData (retireMemData),
		.retireFlags   (retireFlags)
	);

	function automatic logic [31:0] nextRand();
		return $random(seed);
	endfunction

	function automatic logic [4:0] randomReg();
		logic [31:0] r;
		r = nextRand();
		return r[4:0];
	endfunction

	// Encoders
	function automatic logic [31:0] addiWord(input logic [4:0] rd, input logic [4:0] rn,
		input logic [11:0] imm12);
		return {opAddi, imm12, rn, rd};
	endfunction

	function automatic logic [31:0] arithWord(input logic [10:0] op, input logic [4:0] rd,
		input logic [4:0] rn, input logic [4:0] rm);
		return {op, rm, 6'd0, rn, rd};
	endfunction

	function automatic logic [31:0] memWord(input logic [10:0] op, input logic [4:0] rt,
		input logic [4:0] rn, input logic [8:0] addr9);
		return {op, addr9, 2'b00, rn, rt};
	endfunction

	function automatic logic [31:0] cbzWord(input logic [4:0] rt, input logic [18:0] addr19);
		return {opCbz, addr19, rt};
	endfunction

	function automatic logic [31:0] blWord(input logic [25:0] addr26);
		return {opBl, addr26};
	endfunction

	// ADDI, ADDS, SUBS, or a doubling ADDS that walks toward overflow
	function automatic logic [31:0] randomArithWord();
		logic [31:0] r;
		logic [4:0]  d;
		int          kind;
		r    = nextRand();
		d    = randomReg();
		kind = r % 4;
		case (kind)
			0:       return addiWord(d, randomReg(), r[31:20]);
			1:       return arithWord(opAdds, d, randomReg(), randomReg());
			2:       return arithWord(opSubs, d, randomReg(), randomReg());
			default: return arithWord(opAdds, d, d, d);
		endcase
	endfunction

	function automatic logic [31:0] randomLegalWord();
		logic [31:0] r;
		logic [4:0]  base;
		int          kind;
		r    = nextRand();
		kind = r % 5;
		// Base register is X31 half the time
		base = r[3] ? 5'd31 : randomReg();
		case (kind)
			0:       return randomArithWord();
			1:       return memWord(opLdur, randomReg(), base, r[31:23]);
			2:       return memWord(opStur, randomReg(), base, r[31:23]);
			3:       return cbzWord(r[4] ? 5'd31 : randomReg(), r[31:13]);
			default: return blWord(r[31:6]);
		endcase
	endfunction

	// Opcodes the core leaves unsupported, plus raw random words
	function automatic logic [31:0] randomIllegalWord();
		logic [31:0] r;
		int          kind;
		r    = nextRand();
		kind = nextRand() % 13;
		case (kind)
			0:       return {11'b10001011000, r[20:0]};
			1:       return {11'b11001011000, r[20:0]};
			2:       return {11'b10001010000, r[20:0]};
			3:       return {11'b10101010000, r[20:0]};
			4:       return {11'b11001010000, r[20:0]};
			5:       return {11'b11010011011, r[20:0]};
			6:       return {11'b11010011010, r[20:0]};
			7:       return {10'b1101000100, r[21:0]};
			8:       return {10'b1001001000, r[21:0]};
			9:       return {8'b10110101, r[23:0]};
			10:      return {6'b000101, r[25:0]};
			11:      return {8'b01010100, r[23:0]};
			default: return r;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR %s at %0t: expected 0x%h, got 0x%h", name, $time, expected, actual);
		end
	endtask

	// Retire outputs against the model record
	task automatic compareRetire();
		checkValue("retireValid", 64'(expValid), 64'(retireValid));
		checkValue("retireIllegal", 64'(expIllegal), 64'(retireIllegal));
		checkValue("retireRegWe", 64'(expRegWe), 64'(retireRegWe));
		checkValue("retireMemWe", 64'(expMemWe), 64'(retireMemWe));
		if (expValid) begin
			checkValue("retirePc", expPc, retirePc);
			checkValue("retireFlags", 64'(expFlags), 64'(retireFlags));
		end
		if (expRegWe) begin
			checkValue("retireRegAddr", 64'(expRegAddr), 64'(retireRegAddr));
			checkValue("retireRegData", expRegData, retireRegData);
		end
		if (expMemWe) begin
			checkValue("retireMemAddr", expMemAddr, retireMemAddr);
			checkValue("retireMemData", expMemData, retireMemData);
		end
	endtask

	// One clock: check last retire, then drive the next slot on the falling edge
	task automatic runCycle(input logic valid, input logic [31:0] word);
		@(negedge clk);
		compareRetire();
		if (valid) begin
			predictRetire(word);
		end else begin
			expectIdle();
		end
		instrValid = valid;
		instr      = word;
		cycleCount++;
	endtask

	// Flush the last retire and report
	task automatic finishTest(input string name, input int errStart, input int cycStart);
		int errs;
		runCycle(1'b0, nextRand());
		errs = errorCount - errStart;
		if (errs == 0) begin
			testsPassed++;
		end else begin
			testsFailed++;
		end
		$display("Test %s finished after %0d cycles with %0d mismatches: %s",
			name, cycleCount - cycStart, errs, (errs == 0) ? "ok" : "bad");
	endtask

	initial begin
		int          errStart;
		int          cycStart;
		int          kind;
		logic [31:0] r;
		logic [4:0]  rn;
		logic [8:0]  off;
		seed        = 32'h69e00bb9;
		errorCount  = 0;
		checkCount  = 0;
		cycleCount  = 0;
		testsPassed = 0;
		testsFailed = 0;
		rst         = 1'b1;
		instr       = '0;
		instrValid  = 1'b0;
		clearArchState();
		repeat (16) @(negedge clk);
		rst = 1'b0;

		// Reset and idle, then one instruction at pc 0
		errStart = errorCount;
		cycStart = cycleCount;
		repeat (idleCount) runCycle(1'b0, nextRand());
		runCycle(1'b1, addiWord(5'd1, 5'd31, 12'h001));
		finishTest("reset_idle", errStart, cycStart);

		// Arithmetic
		errStart = errorCount;
		cycStart = cycleCount;
		for (int i = 0; i < arithCount; i++) begin
			runCycle(1'b1, randomArithWord());
		end
		// X3 doubled up to the sign bit
		runCycle(1'b1, addiWord(5'd3, 5'd31, 12'h001));
		repeat (63) runCycle(1'b1, arithWord(opAdds, 5'd3, 5'd3, 5'd3));
		// Wraps to zero with carry and overflow
		runCycle(1'b1, arithWord(opAdds, 5'd4, 5'd3, 5'd3));
		runCycle(1'b1, arithWord(opSubs, 5'd5, 5'd31, 5'd3));
		// Dropped write, then X31 read back
		runCycle(1'b1, addiWord(5'd31, 5'd5, 12'd100));
		runCycle(1'b1, arithWord(opAdds, 5'd2, 5'd31, 5'd31));
		finishTest("arithmetic", errStart, cycStart);

		// Store then load from the same doubleword
		errStart = errorCount;
		cycStart = cycleCount;
		for (int i = 0; i < memPairs; i++) begin
			r   = nextRand();
			rn  = (r[1:0] == 2'b00) ? randomReg() : 5'd31;
			off = r[16:8];
			runCycle(1'b1, memWord(opStur, randomReg(), rn, off));
			runCycle(1'b1, memWord(opLdur, randomReg(), rn, {off[8:3], r[22:20]}));
		end
		finishTest("memory", errStart, cycStart);

		// CBZ taken, CBZ on a random register, BL
		errStart = errorCount;
		cycStart = cycleCount;
		for (int i = 0; i < ctrlCount; i++) begin
			r    = nextRand();
			kind = r % 3;
			case (kind)
				0:       runCycle(1'b1, cbzWord(5'd31, r[26:8]));
				1:       runCycle(1'b1, cbzWord(randomReg(), r[26:8]));
				default: runCycle(1'b1, blWord(r[31:6]));
			endcase
		end
		finishTest("control_flow", errStart, cycStart);

		errStart = errorCount;
		cycStart = cycleCount;
		for (int i = 0; i < illegalCount; i++) begin
			runCycle(1'b1, randomIllegalWord());
		end
		finishTest("illegal", errStart, cycStart);

		// Mixed traffic, gaps on about a quarter of the slots
		errStart = errorCount;
		cycStart = cycleCount;
		for (int i = 0; i < mixedCount; i++) begin
			r = nextRand();
			if (r[1:0] == 2'b00) begin
				runCycle(1'b0, nextRand());
			end
			if (r[3:2] == 2'b00) begin
				runCycle(1'b1, randomIllegalWord());
			end else begin
				runCycle(1'b1, randomLegalWord());
			end
		end
		finishTest("mixed", errStart, cycStart);

		$display("Summary: %0d tests passed, %0d tests failed, %0d of %0d checks mismatched",
			testsPassed, testsFailed, errorCount, checkCount);
		if (testsFailed == 0 && errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Watchdog, twice the expected run length
	initial begin
		#(watchdogNs);
		$display("Timeout: the run did not complete within %0d ns", watchdogNs);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+tests
logic/legIsaPkg.sv
logic/legCtrlPkg.sv
logic/aluControlUnit.sv
logic/instrFrontEnd.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/dataMemory.sv
logic/legCore.sv
tests/legCoreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module legCoreTb -o legCoreSim

./obj_dir/legCoreSim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failure"
